/* verilog/smem_config.svh */
`ifndef SMEM_CONFIG_SVH
`define SMEM_CONFIG_SVH

// batch sizing
`define SMEM_MAX_READ 64
`define SMEM_READ_NUM_W 6

// bank split, top read-number bits pick the bank
`define SMEM_BANKS 8
`define SMEM_BANK_SEL_W 3

// per-read mem queue
`define SMEM_MAX_MEM 20
`define SMEM_MEM_CNT_W 7
`define SMEM_RET_W 7

// local read index times slots, plus slot
`define SMEM_BANK_ADDR_W 8

`define SMEM_LINE_W 512

`endif

/* verilog/smem_pkg.sv */
`default_nettype none
`include "smem_config.svh"

package smem_pkg;

	// stored interval, 113 bits
	typedef struct packed {
		logic [6:0]  info_hi;
		logic [6:0]  info_lo;
		logic [32:0] x2;
		logic [32:0] x1;
		logic [32:0] x0;
	} smem_entry_t;

	// datapath form of one entry, padding is zero
	typedef struct packed {
		logic [24:0] pad4;
		logic [6:0]  info_hi;
		logic [24:0] pad3;
		logic [6:0]  info_lo;
		logic [30:0] pad2;
		logic [32:0] x2;
		logic [30:0] pad1;
		logic [32:0] x1;
		logic [30:0] pad0;
		logic [32:0] x0;
	} slot_word_t;

	// --------------------------------------------------
	// output line views
	// --------------------------------------------------
	typedef struct packed {
		logic [351:0] pad_hi;
		logic [31:0]  ret;
		logic [56:0]  pad_mid;
		logic [6:0]   mem_cnt;
		logic [63:0]  read_num;
	} line_header_t;

	typedef struct packed {
		slot_word_t hi;
		slot_word_t lo;
	} line_pair_t;

	// one output word, header or entry pair
	typedef union packed {
		line_header_t hdr;
		line_pair_t   pair;
	} out_line_u;

	// --------------------------------------------------
	// mem queue requests
	// --------------------------------------------------
	typedef struct packed {
		logic                         we;
		logic [`SMEM_READ_NUM_W-1:0]  read_num;
		logic [`SMEM_MEM_CNT_W-1:0]   slot;
		smem_entry_t                  data;
	} mem_wr_t;

	// reads slot on port a, slot+1 on port b
	typedef struct packed {
		logic                         en;
		logic [`SMEM_READ_NUM_W-1:0]  read_num;
		logic [`SMEM_MEM_CNT_W-1:0]   slot;
	} mem_rd_t;

endpackage

`default_nettype wire

/* verilog/mem_entry_writer.sv */
`timescale 1ns/1ps
`include "smem_config.svh"
`default_nettype none

module mem_entry_writer
	import smem_pkg::*;
(
	input  wire                           clk,
	input  wire                           reset_n,
	input  wire                           stall,
	input  wire                           mem_we,
	input  wire [`SMEM_READ_NUM_W-1:0]    mem_read_num,
	input  wire [`SMEM_MEM_CNT_W-1:0]     mem_addr,
	input  wire slot_word_t               mem_data,
	output mem_wr_t                       wr
);
	smem_entry_t entry;

	// strip the padding
	always_comb begin
		entry.info_hi = mem_data.info_hi;
		entry.info_lo = mem_data.info_lo;
		entry.x2      = mem_data.x2;
		entry.x1      = mem_data.x1;
		entry.x0      = mem_data.x0;
	end

	// --------------------------------------------------
	// input register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr.we <= 1'b0;
		end else if (!stall) begin
			wr.we       <= mem_we;
			wr.read_num <= mem_read_num;
			wr.slot     <= mem_addr;
			wr.data     <= entry;
		end
	end

	slot_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		mem_we |-> mem_addr < `SMEM_MAX_MEM)
		else $error("mem write slot %0d out of range", mem_addr);

endmodule

`default_nettype wire

/* verilog/mem_queue_ram.sv */
`timescale 1ns/1ps
`include "smem_config.svh"
`default_nettype none

module mem_queue_ram
	import smem_pkg::*;
(
	input  wire               clk,
	input  wire               stall,
	input  wire mem_wr_t      wr,
	input  wire mem_rd_t      rd,
	output smem_entry_t       q_a,
	output smem_entry_t       q_b
);
	localparam int NB         = `SMEM_BANKS;
	localparam int AW         = `SMEM_BANK_ADDR_W;
	localparam int LOCAL_W    = `SMEM_READ_NUM_W - `SMEM_BANK_SEL_W;
	localparam int BANK_DEPTH = (`SMEM_MAX_READ / `SMEM_BANKS) * `SMEM_MAX_MEM;

	function automatic logic [AW-1:0] flat_addr(
		input logic [LOCAL_W-1:0]         idx,
		input logic [`SMEM_MEM_CNT_W-1:0] slot
	);
		return AW'(idx * `SMEM_MAX_MEM + slot);
	endfunction

	// decode stage of the write path
	logic [NB-1:0]               a_we_q;
	logic [AW-1:0]               a_addr_q;
	smem_entry_t                 a_data_q;
	logic                        a_we_any;

	logic [`SMEM_BANK_SEL_W-1:0] wr_bank;
	logic [`SMEM_BANK_SEL_W-1:0] rd_bank;
	logic [`SMEM_BANK_SEL_W-1:0] rd_bank_q;

	logic [AW-1:0]               port_a_addr;
	logic [AW-1:0]               port_b_addr;

	smem_entry_t                 q_a_bank [NB];
	smem_entry_t                 q_b_bank [NB];

	assign wr_bank = wr.read_num[`SMEM_READ_NUM_W-1 -: `SMEM_BANK_SEL_W];
	assign rd_bank = rd.read_num[`SMEM_READ_NUM_W-1 -: `SMEM_BANK_SEL_W];

	always_ff @(posedge clk) begin
		if (!stall) begin
			a_we_q    <= {{(NB-1){1'b0}}, wr.we} << wr_bank;
			a_addr_q  <= flat_addr(wr.read_num[LOCAL_W-1:0], wr.slot);
			a_data_q  <= wr.data;
			rd_bank_q <= rd_bank;
		end
	end

	// --------------------------------------------------
	// port a arbiter, a pending write beats the streamer
	// --------------------------------------------------
	assign a_we_any    = |a_we_q;
	assign port_a_addr = a_we_any ? a_addr_q : flat_addr(rd.read_num[LOCAL_W-1:0], rd.slot);
	assign port_b_addr = flat_addr(rd.read_num[LOCAL_W-1:0], rd.slot + 1'b1);

	for (genvar b = 0; b < NB; b++) begin : g_bank
		smem_entry_t mem [BANK_DEPTH];

		always_ff @(posedge clk) begin
			if (!stall) begin
				if (a_we_q[b])
					mem[port_a_addr] <= a_data_q;
				q_a_bank[b] <= mem[port_a_addr];
				q_b_bank[b] <= mem[port_b_addr];
			end
		end
	end

	// bank select register
	always_ff @(posedge clk) begin
		if (!stall) begin
			q_a <= q_a_bank[rd_bank_q];
			q_b <= q_b_bank[rd_bank_q];
		end
	end

	// writer and streamer must not meet on port a
	a_port_collision: assert property (@(posedge clk) disable iff (stall)
		a_we_any |-> !rd.en)
		else $error("mem queue port a collision between write and streamer read");

endmodule

`default_nettype wire

/* verilog/batch_tracker.sv */
`timescale 1ns/1ps
`include "smem_config.svh"
`default_nettype none

module batch_tracker (
	input  wire                           clk,
	input  wire                           reset_n,
	input  wire                           stall,
	input  wire [`SMEM_READ_NUM_W:0]      batch_size,
	input  wire                           mem_size_valid,
	input  wire [`SMEM_MEM_CNT_W-1:0]     mem_size,
	input  wire [`SMEM_READ_NUM_W-1:0]    mem_size_read_num,
	input  wire                           ret_valid,
	input  wire [`SMEM_RET_W-1:0]         ret,
	input  wire [`SMEM_READ_NUM_W-1:0]    ret_read_num,
	input  wire [`SMEM_READ_NUM_W-1:0]    lookup_read_num,
	output logic [`SMEM_MEM_CNT_W-1:0]    lookup_mem_cnt,
	output logic [`SMEM_RET_W-1:0]        lookup_ret,
	output logic [`SMEM_READ_NUM_W:0]     done_counter,
	output logic                          output_request
);
	logic [`SMEM_MEM_CNT_W-1:0]  mem_cnt_tab [`SMEM_MAX_READ];
	logic [`SMEM_RET_W-1:0]      ret_tab [`SMEM_MAX_READ];

	logic                        size_valid_q;
	logic [`SMEM_MEM_CNT_W-1:0]  size_q;
	logic [`SMEM_READ_NUM_W-1:0] size_read_num_q;
	logic                        ret_valid_q;
	logic [`SMEM_RET_W-1:0]      ret_q;
	logic [`SMEM_READ_NUM_W-1:0] ret_read_num_q;

	logic                        all_done;
	logic [`SMEM_MAX_READ-1:0]   reported;

	// report input register
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			size_valid_q <= 1'b0;
			ret_valid_q  <= 1'b0;
		end else if (!stall) begin
			size_valid_q    <= mem_size_valid;
			size_q          <= mem_size;
			size_read_num_q <= mem_size_read_num;
			ret_valid_q     <= ret_valid;
			ret_q           <= ret;
			ret_read_num_q  <= ret_read_num;
		end
	end

	// --------------------------------------------------
	// per-read tables and lookup port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!stall) begin
			if (size_valid_q)
				mem_cnt_tab[size_read_num_q] <= size_q;
			if (ret_valid_q)
				ret_tab[ret_read_num_q] <= ret_q;
			lookup_mem_cnt <= mem_cnt_tab[lookup_read_num];
			lookup_ret     <= ret_tab[lookup_read_num];
		end
	end

	// completion
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			done_counter   <= '0;
			all_done       <= 1'b0;
			output_request <= 1'b0;
			reported       <= '0;
		end else if (!stall) begin
			if (size_valid_q) begin
				done_counter              <= done_counter + 1'b1;
				reported[size_read_num_q] <= 1'b1;
			end
			all_done       <= (done_counter == batch_size) && (batch_size != '0);
			output_request <= all_done;
		end
	end

	single_report: assert property (@(posedge clk) disable iff (!reset_n)
		(size_valid_q && !stall) |-> !reported[size_read_num_q])
		else $error("read %0d reported its mem count twice", size_read_num_q);

endmodule

`default_nettype wire

/* verilog/result_streamer.sv */
`timescale 1ns/1ps
`include "smem_config.svh"
`default_nettype none

module result_streamer
	import smem_pkg::*;
(
	input  wire                           clk,
	input  wire                           reset_n,
	input  wire                           stall,
	input  wire [`SMEM_READ_NUM_W:0]      batch_size,
	input  wire                           output_permit,
	output logic [`SMEM_READ_NUM_W-1:0]   lookup_read_num,
	input  wire [`SMEM_MEM_CNT_W-1:0]     lookup_mem_cnt,
	input  wire [`SMEM_RET_W-1:0]         lookup_ret,
	output mem_rd_t                       rd,
	input  wire smem_entry_t              q_a,
	input  wire smem_entry_t              q_b,
	output out_line_u                     output_data,
	output logic                          output_valid,
	output logic                          output_finish
);
	typedef enum logic [2:0] {
		S_HEADER,
		S_PAIRS,
		S_SINGLE,
		S_NEXT,
		S_DONE
	} state_t;

	// line kind and header fields, delayed alongside the ram read
	typedef struct packed {
		logic                        valid;
		logic                        finish;
		logic                        is_hdr;
		logic                        single;
		logic [`SMEM_READ_NUM_W-1:0] read_num;
		logic [`SMEM_MEM_CNT_W-1:0]  mem_cnt;
		logic [`SMEM_RET_W-1:0]      ret;
	} line_tag_t;

	function automatic slot_word_t pad_entry(input smem_entry_t e);
		slot_word_t w;
		w         = '0;
		w.info_hi = e.info_hi;
		w.info_lo = e.info_lo;
		w.x2      = e.x2;
		w.x1      = e.x1;
		w.x0      = e.x0;
		return w;
	endfunction

	state_t                     state;
	logic [`SMEM_READ_NUM_W:0]  read_ptr;
	logic [`SMEM_MEM_CNT_W-1:0] slot;
	line_tag_t                  tag_in;
	line_tag_t                  tag_q1;
	line_tag_t                  tag_q2;
	out_line_u                  line_next;

	// tracker answers one cycle late, so look ahead on the read step
	assign lookup_read_num = (state == S_NEXT) ? read_ptr[`SMEM_READ_NUM_W-1:0] + 1'b1
	                                           : read_ptr[`SMEM_READ_NUM_W-1:0];

	always_comb begin
		tag_in          = '0;
		tag_in.read_num = read_ptr[`SMEM_READ_NUM_W-1:0];
		tag_in.mem_cnt  = lookup_mem_cnt;
		tag_in.ret      = lookup_ret;
		tag_in.finish   = (state == S_DONE);
		if (output_permit) begin
			case (state)
				S_HEADER: begin
					tag_in.valid  = (read_ptr < batch_size);
					tag_in.is_hdr = 1'b1;
				end
				S_PAIRS:  tag_in.valid = 1'b1;
				S_SINGLE: begin
					tag_in.valid  = 1'b1;
					tag_in.single = 1'b1;
				end
				default: ;
			endcase
		end
		rd.en       = tag_in.valid && !tag_in.is_hdr;
		rd.read_num = read_ptr[`SMEM_READ_NUM_W-1:0];
		rd.slot     = slot;
	end

	// --------------------------------------------------
	// sequencer
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state    <= S_HEADER;
			read_ptr <= '0;
			slot     <= '0;
		end else if (!stall && output_permit) begin
			case (state)
				S_HEADER: begin
					slot <= '0;
					if (read_ptr >= batch_size)
						state <= S_DONE;
					else if (lookup_mem_cnt >= 2)
						state <= S_PAIRS;
					else if (lookup_mem_cnt == 1)
						state <= S_SINGLE;
					else
						state <= S_NEXT;
				end
				S_PAIRS: begin
					slot <= slot + 2'd2;
					if (slot + 4 <= lookup_mem_cnt)
						state <= S_PAIRS;
					else if (slot + 3 == lookup_mem_cnt)
						state <= S_SINGLE;
					else
						state <= S_NEXT;
				end
				S_SINGLE: state <= S_NEXT;
				// gap cycle between read groups
				S_NEXT: begin
					read_ptr <= read_ptr + 1'b1;
					state    <= S_HEADER;
				end
				default: state <= S_DONE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			tag_q1 <= '0;
			tag_q2 <= '0;
		end else if (!stall) begin
			tag_q1 <= tag_in;
			tag_q2 <= tag_q1;
		end
	end

	// line assembly, header view or pair view of the same word
	always_comb begin
		line_next = '0;
		if (tag_q2.is_hdr) begin
			line_next.hdr.read_num = 64'(tag_q2.read_num);
			line_next.hdr.mem_cnt  = tag_q2.mem_cnt;
			line_next.hdr.ret      = 32'(tag_q2.ret);
		end else begin
			line_next.pair.lo = pad_entry(q_a);
			if (!tag_q2.single)
				line_next.pair.hi = pad_entry(q_b);
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			output_valid  <= 1'b0;
			output_finish <= 1'b0;
		end else if (!stall) begin
			output_valid  <= tag_q2.valid;
			output_finish <= tag_q2.finish;
			output_data   <= line_next;
		end
	end

endmodule

`default_nettype wire

/* verilog/smem_result_buffer.sv */
`timescale 1ns/1ps
`include "smem_config.svh"
`default_nettype none

module smem_result_buffer
	import smem_pkg::*;
(
	input  wire                           clk,
	input  wire                           reset_n,
	input  wire                           stall,
	input  wire [`SMEM_READ_NUM_W:0]      batch_size,
	// datapath mem write
	input  wire                           mem_we,
	input  wire [`SMEM_READ_NUM_W-1:0]    mem_read_num,
	input  wire [`SMEM_MEM_CNT_W-1:0]     mem_addr,
	input  wire slot_word_t               mem_data,
	// per-read reports
	input  wire                           mem_size_valid,
	input  wire [`SMEM_MEM_CNT_W-1:0]     mem_size,
	input  wire [`SMEM_READ_NUM_W-1:0]    mem_size_read_num,
	input  wire                           ret_valid,
	input  wire [`SMEM_RET_W-1:0]         ret,
	input  wire [`SMEM_READ_NUM_W-1:0]    ret_read_num,
	output logic [`SMEM_READ_NUM_W:0]     done_counter,
	// output side
	output logic                          output_request,
	input  wire                           output_permit,
	output out_line_u                     output_data,
	output logic                          output_valid,
	output logic                          output_finish
);
	mem_wr_t                     wr;
	mem_rd_t                     rd;
	smem_entry_t                 q_a;
	smem_entry_t                 q_b;
	logic [`SMEM_READ_NUM_W-1:0] lookup_read_num;
	logic [`SMEM_MEM_CNT_W-1:0]  lookup_mem_cnt;
	logic [`SMEM_RET_W-1:0]      lookup_ret;

	mem_entry_writer u_writer (
		.clk          (clk),
		.reset_n      (reset_n),
		.stall        (stall),
		.mem_we       (mem_we),
		.mem_read_num (mem_read_num),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.wr           (wr)
	);

	mem_queue_ram u_ram (
		.clk   (clk),
		.stall (stall),
		.wr    (wr),
		.rd    (rd),
		.q_a   (q_a),
		.q_b   (q_b)
	);

	batch_tracker u_tracker (
		.clk               (clk),
		.reset_n           (reset_n),
		.stall             (stall),
		.batch_size        (batch_size),
		.mem_size_valid    (mem_size_valid),
		.mem_size          (mem_size),
		.mem_size_read_num (mem_size_read_num),
		.ret_valid         (ret_valid),
		.ret               (ret),
		.ret_read_num      (ret_read_num),
		.lookup_read_num   (lookup_read_num),
		.lookup_mem_cnt    (lookup_mem_cnt),
		.lookup_ret        (lookup_ret),
		.done_counter      (done_counter),
		.output_request    (output_request)
	);

	result_streamer u_streamer (
		.clk             (clk),
		.reset_n         (reset_n),
		.stall           (stall),
		.batch_size      (batch_size),
		.output_permit   (output_permit),
		.lookup_read_num (lookup_read_num),
		.lookup_mem_cnt  (lookup_mem_cnt),
		.lookup_ret      (lookup_ret),
		.rd              (rd),
		.q_a             (q_a),
		.q_b             (q_b),
		.output_data     (output_data),
		.output_valid    (output_valid),
		.output_finish   (output_finish)
	);

endmodule

`default_nettype wire

/* dv/result_checker.sv */
`timescale 1ns/1ps
`include "smem_config.svh"
`default_nettype none

module result_checker (
	input  wire                          clk,
	input  wire                          reset_n,
	input  wire                          stall,
	input  wire [`SMEM_READ_NUM_W:0]     batch_size,
	input  wire                          mem_we,
	input  wire [`SMEM_READ_NUM_W-1:0]   mem_read_num,
	input  wire [`SMEM_MEM_CNT_W-1:0]    mem_addr,
	input  wire [255:0]                  mem_data,
	input  wire                          mem_size_valid,
	input  wire [`SMEM_MEM_CNT_W-1:0]    mem_size,
	input  wire [`SMEM_READ_NUM_W-1:0]   mem_size_read_num,
	input  wire                          ret_valid,
	input  wire [`SMEM_RET_W-1:0]        ret,
	input  wire [`SMEM_READ_NUM_W-1:0]   ret_read_num,
	input  wire [`SMEM_READ_NUM_W:0]     done_counter,
	input  wire                          output_request,
	input  wire [`SMEM_LINE_W-1:0]       output_data,
	input  wire                          output_valid,
	input  wire                          output_finish,
	input  wire [3:0]                    test_id,
	input  wire                          test_end,
	input  wire                          tb_error,
	input  wire                          run_end,
	output int                           error_count
);
	logic [255:0]               entry_model [`SMEM_MAX_READ * `SMEM_MAX_MEM];
	logic [`SMEM_MEM_CNT_W-1:0] cnt_model [`SMEM_MAX_READ];
	logic [`SMEM_RET_W-1:0]     ret_model [`SMEM_MAX_READ];

	logic [`SMEM_LINE_W-1:0]    exp_q [$];
	int                         exp_read_q [$];
	logic [`SMEM_LINE_W-1:0]    exp_line;
	int                         exp_read;

	int                         reports_seen;
	int                         lines_checked;
	int                         test_errors;
	int                         tests_passed;
	int                         tests_failed;
	bit                         reset_q;
	bit                         req_seen;
	bit                         finish_seen;

	// data fields of a padded slot word
	function automatic logic [255:0] field_mask();
		logic [255:0] m;
		m          = '0;
		m[230:224] = '1;
		m[198:192] = '1;
		m[160:128] = '1;
		m[96:64]   = '1;
		m[32:0]    = '1;
		return m;
	endfunction

	// --------------------------------------------------
	// reference line list for reads 0 to n-1
	// --------------------------------------------------
	function automatic void build_expected(input int n);
		logic [`SMEM_LINE_W-1:0] line;
		int                      cnt;
		for (int r = 0; r < n; r++) begin
			cnt           = cnt_model[r];
			line          = '0;
			line[63:0]    = 64'(r);
			line[70:64]   = cnt_model[r];
			line[159:128] = 32'(ret_model[r]);
			exp_q.push_back(line);
			exp_read_q.push_back(r);
			for (int s = 0; s < cnt; s += 2) begin
				line        = '0;
				line[255:0] = entry_model[r * `SMEM_MAX_MEM + s] & field_mask();
				// odd tail keeps a zero hi half
				if (s + 1 < cnt)
					line[511:256] = entry_model[r * `SMEM_MAX_MEM + s + 1] & field_mask();
				exp_q.push_back(line);
				exp_read_q.push_back(r);
			end
		end
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1: return "reset values";
			2: return "report counting and output_request";
			3: return "stream of a random batch";
			4: return "end of stream";
			5: return "zero and odd counts under stall and permit toggling";
			default: return "unknown";
		endcase
	endfunction

	task automatic log_mismatch(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	task automatic log_failure(input string msg);
		$display("%0t ns: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	always @(posedge clk) begin
		if (!reset_n) begin
			reports_seen = 0;
			req_seen     = 1'b0;
			finish_seen  = 1'b0;
			exp_q.delete();
			exp_read_q.delete();
		end else begin
			if (!reset_q && (output_request || output_valid || output_finish ||
			                 done_counter != 0))
				log_mismatch("control outputs not zero after reset");

			// copy of the datapath traffic
			if (!stall) begin
				if (mem_we)
					entry_model[mem_read_num * `SMEM_MAX_MEM + mem_addr] = mem_data;
				if (mem_size_valid) begin
					cnt_model[mem_size_read_num] = mem_size;
					reports_seen++;
				end
				if (ret_valid)
					ret_model[ret_read_num] = ret;
			end

			if (done_counter > reports_seen)
				log_mismatch($sformatf("done_counter %0d is ahead of %0d reports",
				                       done_counter, reports_seen));
			if (output_request && !req_seen) begin
				req_seen = 1'b1;
				if (reports_seen != batch_size)
					log_failure($sformatf("output_request rose after %0d of %0d reports",
					                      reports_seen, batch_size));
				if (done_counter != reports_seen)
					log_mismatch($sformatf("done_counter is %0d, expected %0d",
					                       done_counter, reports_seen));
				build_expected(batch_size);
			end else if (req_seen && !output_request) begin
				log_failure("output_request dropped while the batch was complete");
			end

			// line compare
			if (!stall && output_valid) begin
				if (exp_q.size() == 0) begin
					log_failure("a valid output line came with no line left to expect");
				end else begin
					exp_line = exp_q.pop_front();
					exp_read = exp_read_q.pop_front();
					lines_checked++;
					if (output_data !== exp_line)
						log_mismatch($sformatf("read %0d line, expected %h, got %h",
						                       exp_read, exp_line, output_data));
				end
			end

			if (output_finish && !finish_seen) begin
				finish_seen = 1'b1;
				if (exp_q.size() != 0)
					log_failure($sformatf("output_finish rose with %0d lines missing",
					                      exp_q.size()));
			end else if (finish_seen && !output_finish) begin
				log_failure("output_finish dropped after it was set");
			end
		end

		if (tb_error) begin
			error_count++;
			test_errors++;
		end

		// --------------------------------------------------
		// per-test result and closing counts
		// --------------------------------------------------
		if (test_end) begin
			if (test_id == 2 && !req_seen)
				log_failure("output_request never rose");
			if (test_id >= 3 && (!finish_seen || exp_q.size() != 0))
				log_failure($sformatf("stream incomplete, %0d lines missing", exp_q.size()));
			if (test_errors == 0) begin
				tests_passed++;
				$display("test %0d (%s) passed", test_id, test_name(test_id));
			end else begin
				tests_failed++;
				$display("test %0d (%s) did not pass, %0d errors", test_id,
				         test_name(test_id), test_errors);
			end
			test_errors = 0;
		end
		if (run_end)
			$display("%0d tests, %0d passed, %0d failed, %0d lines compared, %0d errors",
			         tests_passed + tests_failed, tests_passed, tests_failed,
			         lines_checked, error_count);
		reset_q = reset_n;
	end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`timescale 1ns/1ps
`include "smem_config.svh"
`default_nettype none

module tb_top
	import smem_pkg::*;
();
	localparam int CLK_PERIOD = 100;
	localparam int BATCH_A    = 64;
	localparam int BATCH_B    = 32;
	// each read gets up to 30 cycles to load and as many to stream
	localparam longint WATCHDOG_NS =
		longint'(BATCH_A + BATCH_B) * 30 * 2 * CLK_PERIOD + 200 * CLK_PERIOD;

	logic                         clk = 1'b0;
	logic                         reset_n;
	logic                         stall;
	logic [`SMEM_READ_NUM_W:0]    batch_size;
	logic                         mem_we;
	logic [`SMEM_READ_NUM_W-1:0]  mem_read_num;
	logic [`SMEM_MEM_CNT_W-1:0]   mem_addr;
	slot_word_t                   mem_data;
	logic                         mem_size_valid;
	logic [`SMEM_MEM_CNT_W-1:0]   mem_size;
	logic [`SMEM_READ_NUM_W-1:0]  mem_size_read_num;
	logic                         ret_valid;
	logic [`SMEM_RET_W-1:0]       ret;
	logic [`SMEM_READ_NUM_W-1:0]  ret_read_num;
	logic                         output_permit;
	logic [`SMEM_READ_NUM_W:0]    done_counter;
	logic                         output_request;
	out_line_u                    output_data;
	logic                         output_valid;
	logic                         output_finish;

	logic [3:0]                   test_id;
	logic                         test_end;
	logic                         tb_error;
	logic                         run_end;
	int                           error_count;

	always #(CLK_PERIOD / 2) clk = ~clk;

	smem_result_buffer u_dut (
		.clk               (clk),
		.reset_n           (reset_n),
		.stall             (stall),
		.batch_size        (batch_size),
		.mem_we            (mem_we),
		.mem_read_num      (mem_read_num),
		.mem_addr          (mem_addr),
		.mem_data          (mem_data),
		.mem_size_valid    (mem_size_valid),
		.mem_size          (mem_size),
		.mem_size_read_num (mem_size_read_num),
		.ret_valid         (ret_valid),
		.ret               (ret),
		.ret_read_num      (ret_read_num),
		.done_counter      (done_counter),
		.output_request    (output_request),
		.output_permit     (output_permit),
		.output_data       (output_data),
		.output_valid      (output_valid),
		.output_finish     (output_finish)
	);

	result_checker u_checker (
		.clk               (clk),
		.reset_n           (reset_n),
		.stall             (stall),
		.batch_size        (batch_size),
		.mem_we            (mem_we),
		.mem_read_num      (mem_read_num),
		.mem_addr          (mem_addr),
		.mem_data          (mem_data),
		.mem_size_valid    (mem_size_valid),
		.mem_size          (mem_size),
		.mem_size_read_num (mem_size_read_num),
		.ret_valid         (ret_valid),
		.ret               (ret),
		.ret_read_num      (ret_read_num),
		.done_counter      (done_counter),
		.output_request    (output_request),
		.output_data       (output_data),
		.output_valid      (output_valid),
		.output_finish     (output_finish),
		.test_id           (test_id),
		.test_end          (test_end),
		.tb_error          (tb_error),
		.run_end           (run_end),
		.error_count       (error_count)
	);

	function automatic slot_word_t random_entry_word();
		slot_word_t w;
		w         = '0;
		w.info_hi = 7'($urandom);
		w.info_lo = 7'($urandom);
		w.x2      = 33'({$urandom, $urandom});
		w.x1      = 33'({$urandom, $urandom});
		w.x0      = 33'({$urandom, $urandom});
		return w;
	endfunction

	task automatic reset_dut();
		reset_n       = 1'b0;
		stall         = 1'b0;
		output_permit = 1'b0;
		repeat (3) @(posedge clk);
		#1 reset_n = 1'b1;
	endtask

	task automatic end_test(input int id);
		test_id  = 4'(id);
		test_end = 1'b1;
		@(posedge clk);
		#1 test_end = 1'b0;
	endtask

	task automatic flag_failure(input string msg);
		$display("%0t: %s", $time, msg);
		tb_error = 1'b1;
		@(posedge clk);
		#1 tb_error = 1'b0;
	endtask

	// --------------------------------------------------
	// batch load with entries first and then the report
	// --------------------------------------------------
	task automatic load_batch(input int n, input bit edge_counts);
		int cnt;
		batch_size = 7'(n);
		for (int r = 0; r < n; r++) begin
			if (!edge_counts)
				cnt = $urandom_range(1, `SMEM_MAX_MEM);
			else if (r % 4 == 0)
				cnt = 0;
			else if (r % 4 == 1)
				cnt = 2 * $urandom_range(0, 9) + 1;
			else
				cnt = $urandom_range(1, `SMEM_MAX_MEM);
			for (int s = 0; s < cnt; s++) begin
				mem_we       = 1'b1;
				mem_read_num = 6'(r);
				mem_addr     = 7'(s);
				mem_data     = random_entry_word();
				@(posedge clk);
				#1;
			end
			mem_we            = 1'b0;
			mem_size_valid    = 1'b1;
			mem_size          = 7'(cnt);
			mem_size_read_num = 6'(r);
			ret_valid         = 1'b1;
			ret               = 7'($urandom);
			ret_read_num      = 6'(r);
			@(posedge clk);
			#1;
			mem_size_valid = 1'b0;
			ret_valid      = 1'b0;
		end
	endtask

	task automatic wait_for_request();
		int cycles;
		cycles = 0;
		while (!output_request && cycles < 50) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!output_request)
			flag_failure("output_request did not rise after the last report");
	endtask

	task automatic stream_batch(input int n, input bit noisy);
		int cycles;
		cycles        = 0;
		output_permit = 1'b1;
		while (!output_finish && cycles < n * 60 + 50) begin
			@(posedge clk);
			#1;
			cycles++;
			if (noisy) begin
				stall         = ($urandom_range(0, 3) == 0);
				output_permit = ($urandom_range(0, 3) != 0);
			end
		end
		stall         = 1'b0;
		output_permit = 1'b1;
		if (!output_finish)
			flag_failure("output_finish did not rise at the end of the stream");
		// last lines still draining
		repeat (4) @(posedge clk);
		#1;
	endtask

	initial begin
		reset_n           = 1'b0;
		stall             = 1'b0;
		batch_size        = '0;
		mem_we            = 1'b0;
		mem_read_num      = '0;
		mem_addr          = '0;
		mem_data          = '0;
		mem_size_valid    = 1'b0;
		mem_size          = '0;
		mem_size_read_num = '0;
		ret_valid         = 1'b0;
		ret               = '0;
		ret_read_num      = '0;
		output_permit     = 1'b0;
		test_id           = '0;
		test_end          = 1'b0;
		tb_error          = 1'b0;
		run_end           = 1'b0;
		void'($urandom(45637));

		reset_dut();
		repeat (2) @(posedge clk);
		#1;
		end_test(1);

		load_batch(BATCH_A, 1'b0);
		wait_for_request();
		end_test(2);

		stream_batch(BATCH_A, 1'b0);
		end_test(3);

		// nothing more may appear while idle after the stream
		repeat (20) @(posedge clk);
		#1;
		end_test(4);

		reset_dut();
		load_batch(BATCH_B, 1'b1);
		wait_for_request();
		stream_batch(BATCH_B, 1'b1);
		end_test(5);

		run_end = 1'b1;
		@(posedge clk);
		#1 run_end = 1'b0;
		if (error_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the run completed");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/smem_pkg.sv
verilog/mem_entry_writer.sv
verilog/mem_queue_ram.sv
verilog/batch_tracker.sv
verilog/result_streamer.sv
verilog/smem_result_buffer.sv
dv/result_checker.sv
dv/tb_top.sv
